// File: wb_defines.svh
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

`define WB_XLEN  32
`define WB_NREGS 32

// RV32I major opcodes.
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LBU 3'b100
`define F3_LHU 3'b101

`endif

// File: wb_pkg.sv
`include "wb_defines.svh"

package wb_pkg;

    // One data or instruction word.
    typedef logic [`WB_XLEN-1:0] word_t;

    typedef logic [$clog2(`WB_NREGS)-1:0] reg_addr_t;

    // Writeback source select.
    typedef logic [1:0] wb_sel_t;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // Select encodings.
    localparam wb_sel_t WB_SEL_MEM = 2'd0;
    localparam wb_sel_t WB_SEL_ALU = 2'd1;
    localparam wb_sel_t WB_SEL_PC4 = 2'd2;

endpackage

// File: wb_ctl.sv
`timescale 1ns/10ps

`include "wb_defines.svh"

module wb_ctl
    import wb_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  word_t   pc_4_acc,
    input  word_t   alu_out_acc,
    input  word_t   dmem_out,
    input  word_t   instr,
    output wb_sel_t wb_sel,
    output logic    reg_wen,
    output word_t   pc_4_wb,
    output word_t   alu_out_wb,
    output word_t   dmem_out_wb,
    output word_t   instr_wb
);

    opcode_t opcode;
    wb_sel_t dec_sel;
    logic    dec_wen;

    assign opcode = instr[6:0];

    // Decode of the instruction waiting at the stage inputs.
    always_comb begin
        dec_sel = WB_SEL_MEM;
        dec_wen = 1'b0;
        case (opcode)
            `OP_LUI, `OP_AUIPC: begin
                dec_sel = WB_SEL_ALU;
                dec_wen = 1'b1;
            end
            `OP_IMM, `OP_REG: begin
                dec_sel = WB_SEL_ALU;
                dec_wen = 1'b1;
            end
            `OP_LOAD: begin
                dec_sel = WB_SEL_MEM;
                dec_wen = 1'b1;
            end
            `OP_JAL, `OP_JALR: begin
                dec_sel = WB_SEL_PC4; // Link address.
                dec_wen = 1'b1;
            end
            `OP_STORE, `OP_BRANCH: begin
                dec_sel = WB_SEL_MEM; // No destination register.
                dec_wen = 1'b0;
            end
            default: begin
                dec_sel = WB_SEL_MEM;
                dec_wen = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_sel      <= WB_SEL_MEM;
            reg_wen     <= 1'b0;
            pc_4_wb     <= '0;
            alu_out_wb  <= '0;
            dmem_out_wb <= '0;
            instr_wb    <= '0; // Clears rd too.
        end else begin
            wb_sel      <= dec_sel;
            reg_wen     <= dec_wen;
            pc_4_wb     <= pc_4_acc;
            alu_out_wb  <= alu_out_acc;
            dmem_out_wb <= dmem_out;
            instr_wb    <= instr;
        end
    end

endmodule

// File: wb_mux.sv
`timescale 1ns/10ps

`include "wb_defines.svh"

module wb_mux
    import wb_pkg::*;
(
    input  wb_sel_t wb_sel,
    input  word_t   pc_4_wb,
    input  word_t   alu_out_wb,
    input  word_t   dmem_out_wb,
    input  word_t   instr_wb,
    output word_t   wb_data
);

    funct3_t     funct3;
    logic [1:0]  offset;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       load_data;

    assign funct3 = instr_wb[14:12];
    assign offset = alu_out_wb[1:0]; // Byte address within the word.

    always_comb begin
        case (offset)
            2'd0:    ld_byte = dmem_out_wb[7:0];
            2'd1:    ld_byte = dmem_out_wb[15:8];
            2'd2:    ld_byte = dmem_out_wb[23:16];
            default: ld_byte = dmem_out_wb[31:24];
        endcase
    end

    assign ld_half = offset[1] ? dmem_out_wb[31:16] : dmem_out_wb[15:0];

    // Extension by load width.
    always_comb begin
        case (funct3)
            `F3_LB:  load_data = {{(`WB_XLEN-8){ld_byte[7]}}, ld_byte};
            `F3_LBU: load_data = {{(`WB_XLEN-8){1'b0}}, ld_byte};
            `F3_LH:  load_data = {{(`WB_XLEN-16){ld_half[15]}}, ld_half};
            `F3_LHU: load_data = {{(`WB_XLEN-16){1'b0}}, ld_half};
            `F3_LW:  load_data = dmem_out_wb;
            default: load_data = dmem_out_wb;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_SEL_ALU: wb_data = alu_out_wb;
            WB_SEL_PC4: wb_data = pc_4_wb;
            WB_SEL_MEM: wb_data = load_data;
            default:    wb_data = load_data;
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/10ps

`include "wb_defines.svh"

module reg_file
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output logic      wr_en
);

    // x0 has no storage.
    word_t regs [1:`WB_NREGS-1];

    assign wr_en = we && (waddr != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `WB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through read.
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (addr == waddr)) begin
            data = wdata; // Value being written this cycle.
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

endmodule

// File: wb_top.sv
`timescale 1ns/10ps

module wb_top
    import wb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     pc_4,
    input  word_t     alu_out,
    input  word_t     dmem_out,
    input  word_t     instr,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    wb_sel_t wb_sel;
    logic    reg_wen;
    word_t   pc_4_wb;
    word_t   alu_out_wb;
    word_t   dmem_out_wb;
    word_t   instr_wb;

    assign wb_rd = instr_wb[11:7]; // Destination register.

    wb_ctl u_wb_ctl (
        .clk         (clk),
        .rst         (rst),
        .pc_4_acc    (pc_4),
        .alu_out_acc (alu_out),
        .dmem_out    (dmem_out),
        .instr       (instr),
        .wb_sel      (wb_sel),
        .reg_wen     (reg_wen),
        .pc_4_wb     (pc_4_wb),
        .alu_out_wb  (alu_out_wb),
        .dmem_out_wb (dmem_out_wb),
        .instr_wb    (instr_wb)
    );

    wb_mux u_wb_mux (
        .wb_sel      (wb_sel),
        .pc_4_wb     (pc_4_wb),
        .alu_out_wb  (alu_out_wb),
        .dmem_out_wb (dmem_out_wb),
        .instr_wb    (instr_wb),
        .wb_data     (wb_data)
    );

    // Also qualifies the write for forwarding.
    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .we       (reg_wen),
        .waddr    (wb_rd),
        .wdata    (wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_en)
    );

endmodule

// File: tb_wb_top.sv
`timescale 1ns/10ps

`include "wb_defines.svh"

module tb_wb_top
    import wb_pkg::*;
();

    logic      clk;
    logic      rst;
    word_t     pc_4;
    word_t     alu_out;
    word_t     dmem_out;
    word_t     instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    word_t shadow [0:`WB_NREGS-1]; // Expected architectural state.
    int    errors;
    int    checks;

    wb_top DUT (
        .clk      (clk),
        .rst      (rst),
        .pc_4     (pc_4),
        .alu_out  (alu_out),
        .dmem_out (dmem_out),
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    always #20 clk = ~clk;

    function automatic bit writes_reg(input word_t ins);
        case (ins[6:0])
            `OP_LUI, `OP_AUIPC, `OP_IMM, `OP_REG: return 1'b1;
            `OP_LOAD, `OP_JAL, `OP_JALR:         return 1'b1;
            default:                             return 1'b0;
        endcase
    endfunction

    // Reference writeback value from the decode and load rules.
    function automatic word_t expected_data(input word_t ins, input word_t pc4,
                                            input word_t alu, input word_t dmem);
        word_t byte_src;
        word_t half_src;
        word_t result;
        byte_src = dmem >> (8 * alu[1:0]);
        half_src = dmem >> (16 * alu[1]);
        case (ins[6:0])
            `OP_JAL, `OP_JALR: result = pc4;
            `OP_LOAD: begin
                case (ins[14:12])
                    `F3_LB:  result = {{24{byte_src[7]}}, byte_src[7:0]};
                    `F3_LBU: result = {24'h0, byte_src[7:0]};
                    `F3_LH:  result = {{16{half_src[15]}}, half_src[15:0]};
                    `F3_LHU: result = {16'h0, half_src[15:0]};
                    default: result = dmem; // LW and unknown widths.
                endcase
            end
            default: result = alu;
        endcase
        return result;
    endfunction

    function automatic word_t make_instr(input opcode_t op, input reg_addr_t rd,
                                         input funct3_t f3);
        word_t ins;
        ins = $urandom;
        ins[6:0] = op;
        ins[11:7] = rd;
        ins[14:12] = f3;
        return ins;
    endfunction

    function automatic reg_addr_t random_rd();
        return reg_addr_t'(1 + ($urandom % 31));
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Starts and ends 2 ns after a rising edge.
    task automatic issue(input word_t ins, input word_t pc4, input word_t alu,
                         input word_t dmem);
        reg_addr_t rd;
        bit        wen;
        word_t     exp;
        word_t     exp_read;
        int        cycles;
        rd = ins[11:7];
        wen = writes_reg(ins);
        exp = expected_data(ins, pc4, alu, dmem);
        instr = ins;
        pc_4 = pc4;
        alu_out = alu;
        dmem_out = dmem;
        rs1_addr = rd;
        rs2_addr = rd;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (wb_rd !== rd && cycles < 8);
        if (wb_rd !== rd) begin
            $display("timeout: instruction %h never reached writeback", ins);
            errors++;
        end else if (cycles != 1) begin
            $display("instruction %h took %0d cycles to reach writeback", ins, cycles);
            errors++;
        end
        compare("wb_rd", wb_rd, rd);
        compare("wb_en", wb_en, wen && rd != 0);
        if (wen) begin
            compare("wb_data", wb_data, exp);
        end
        exp_read = (wen && rd != 0) ? exp : shadow[rd]; // Write-through.
        compare("rs1_data", rs1_data, exp_read);
        compare("rs2_data", rs2_data, exp_read);
        if (wen && rd != 0) begin
            shadow[rd] = exp;
        end
        #1;
    endtask

    task automatic check_all_regs();
        instr = '0; // Opcode 0 writes nothing.
        for (int i = 0; i < `WB_NREGS; i++) begin
            rs1_addr = i;
            rs2_addr = `WB_NREGS - 1 - i;
            #1;
            compare("rs1_data", rs1_data, shadow[i]);
            compare("rs2_data", rs2_data, shadow[`WB_NREGS-1-i]);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic test_reset();
        compare("wb_en", wb_en, 1'b0);
        check_all_regs();
        compare("wb_en", wb_en, 1'b0);
    endtask

    task automatic test_alu_writes();
        opcode_t ops [4];
        ops = '{`OP_REG, `OP_IMM, `OP_LUI, `OP_AUIPC};
        foreach (ops[k]) begin
            repeat (3) begin
                issue(make_instr(ops[k], random_rd(), funct3_t'($urandom)),
                      $urandom, $urandom, $urandom);
            end
        end
        check_all_regs();
    endtask

    task automatic test_loads();
        funct3_t f3s [5];
        int      step;
        word_t   dmem;
        f3s = '{`F3_LB, `F3_LH, `F3_LW, `F3_LBU, `F3_LHU};
        foreach (f3s[k]) begin
            step = (f3s[k] == `F3_LW) ? 4 : (f3s[k] == `F3_LH || f3s[k] == `F3_LHU) ? 2 : 1;
            for (int off = 0; off < 4; off += step) begin
                dmem = $urandom;
                // Inverted data gives the other sign for each lane.
                issue(make_instr(`OP_LOAD, random_rd(), f3s[k]), $urandom,
                      ($urandom & 32'hffff_fffc) | off, dmem);
                issue(make_instr(`OP_LOAD, random_rd(), f3s[k]), $urandom,
                      ($urandom & 32'hffff_fffc) | off, ~dmem);
            end
        end
        check_all_regs();
    endtask

    task automatic test_jumps();
        repeat (2) begin
            issue(make_instr(`OP_JAL, random_rd(), funct3_t'($urandom)),
                  $urandom, $urandom, $urandom);
            issue(make_instr(`OP_JALR, random_rd(), 3'b000), $urandom, $urandom, $urandom);
        end
        check_all_regs();
    endtask

    task automatic test_no_writes();
        issue(make_instr(`OP_STORE, random_rd(), `F3_LW), $urandom, $urandom, $urandom);
        issue(make_instr(`OP_BRANCH, random_rd(), 3'b001), $urandom, $urandom, $urandom);
        issue(make_instr(7'b0001111, random_rd(), 3'b000), $urandom, $urandom, $urandom);
        issue(make_instr(7'b1111111, random_rd(), 3'b111), $urandom, $urandom, $urandom);
        issue(make_instr(`OP_REG, 5'd0, 3'b000), $urandom, $urandom, $urandom);
        issue(make_instr(`OP_LOAD, 5'd0, `F3_LW), $urandom, $urandom, $urandom);
        issue(make_instr(`OP_JAL, 5'd0, 3'b000), $urandom, $urandom, $urandom);
        check_all_regs();
    endtask

    task automatic test_back_to_back();
        opcode_t   ops [9];
        reg_addr_t rd;
        ops = '{`OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR, `OP_BRANCH,
                `OP_LOAD, `OP_STORE, `OP_IMM, `OP_REG};
        rd = random_rd();
        repeat (24) begin
            if ($urandom % 3 != 0) begin
                rd = random_rd(); // Otherwise rewrite the same register.
            end
            issue(make_instr(ops[$urandom % 9], rd, funct3_t'($urandom)),
                  $urandom, $urandom, $urandom);
        end
        check_all_regs();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        pc_4 = '0;
        alu_out = '0;
        dmem_out = '0;
        instr = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        errors = 0;
        checks = 0;
        void'($urandom(32'he983_957a));
        for (int i = 0; i < `WB_NREGS; i++) begin
            shadow[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_alu_writes();
        test_loads();
        test_jumps();
        test_no_writes();
        test_back_to_back();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
wb_pkg.sv
wb_ctl.sv
wb_mux.sv
reg_file.sv
wb_top.sv
tb_wb_top.sv

// File: Bender.yml
package:
  name: wb_top

sources:
  - include_dirs:
      - .
    files:
      - wb_pkg.sv
      - wb_ctl.sv
      - wb_mux.sv
      - reg_file.sv
      - wb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wb_top.sv
